// File: logic/decode_settings.svh
/*
  Widths and major opcode values for the instruction decode stage.
  Include this header wherever one of these macros is used.
*/
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define ILEN       32
`define REG_ADDR_W 5

// RV32I major opcodes
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

`endif

// File: logic/decode_pkg.sv
/*
  Types shared by the decode stage. The scoreboard entry leaves the decoder,
  the issue register holds one of them together with its valid bit.
*/
`include "decode_settings.svh"

package decode_pkg;

  // Functional unit that executes the instruction
  typedef enum logic [2:0] {
    FU_NONE,
    FU_ALU,
    FU_BRANCH,
    FU_LOAD,
    FU_STORE
  } fu_e;

  // Operation within the functional unit
  typedef enum logic [4:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU,
    JAL,
    JALR,
    LUI,
    AUIPC,
    LW,
    SW
  } op_e;

  typedef struct packed {
    logic [31:0]             pc;
    fu_e                     fu;
    op_e                     op;
    logic [`REG_ADDR_W-1:0]  rd;
    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [31:0]             imm;
    logic                    illegal;
    logic                    is_compressed;
    logic                    is_ctrl_flow;
    logic [`ILEN-1:0]        orig_instr;
  } sb_entry_t;

  // Contents of the decode-to-issue register
  typedef struct packed {
    logic      valid;
    sb_entry_t sbe;
  } issue_reg_t;

endpackage

// File: logic/expand_if.sv
/*
  Carries the expanded instruction and its flags from the compressed
  expander to the 32-bit decoder.
*/
`timescale 1ns/10ps
`include "decode_settings.svh"

interface expand_if;

  logic [`ILEN-1:0] instr;
  logic [`ILEN-1:0] fetch_instr;
  logic             is_compressed;
  logic             illegal;

  modport expander (
    output instr,
    output fetch_instr,
    output is_compressed,
    output illegal
  );

  modport decoder (
    input instr,
    input fetch_instr,
    input is_compressed,
    input illegal
  );

endinterface

// File: logic/rvc_expander.sv
/*
  Expands a supported compressed word into its 32-bit equivalent.
  Unsupported compressed words are flagged and give a zero instruction,
  32-bit words pass straight through.
*/
`timescale 1ns/10ps
`include "decode_settings.svh"

module rvc_expander (
  input  logic [`ILEN-1:0] fetch_instr_i,
  expand_if.expander       exp
);

  logic [15:0]            c;
  logic [`REG_ADDR_W-1:0] rd_p;
  logic [`REG_ADDR_W-1:0] rs1_p;
  logic [`ILEN-1:0]       expanded;
  logic                   compressed;
  logic                   rvc_illegal;

  assign c          = fetch_instr_i[15:0];
  assign compressed = fetch_instr_i[1:0] != 2'b11;

  // Three bit register fields address x8 to x15
  assign rd_p  = {2'b01, c[4:2]};
  assign rs1_p = {2'b01, c[9:7]};

  always_comb begin
    expanded    = fetch_instr_i;
    rvc_illegal = 1'b0;

    if (compressed) begin
      expanded    = '0;
      rvc_illegal = 1'b1;

      unique case (c[1:0])
        // ------------------------------------------------------------------------
        // Quadrant 0
        // ------------------------------------------------------------------------
        2'b00: begin
          if (c[15:13] == 3'b010) begin
            // C.LW becomes lw rd', uimm(rs1')
            expanded    = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p,
                           `OPC_LOAD};
            rvc_illegal = 1'b0;
          end else if (c[15:13] == 3'b110) begin
            // C.SW, offset split around the rs2/rs1 fields
            expanded    = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010, c[11:10], c[6], 2'b00,
                           `OPC_STORE};
            rvc_illegal = 1'b0;
          end
        end

        // ------------------------------------------------------------------------
        // Quadrant 1
        // ------------------------------------------------------------------------
        2'b01: begin
          case (c[15:13])
            3'b000: begin
              // C.ADDI, rd = rd + sext(imm6)
              expanded    = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7],
                             `OPC_OP_IMM};
              rvc_illegal = 1'b0;
            end
            3'b010: begin
              // C.LI, rd = x0 + sext(imm6)
              expanded    = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7], `OPC_OP_IMM};
              rvc_illegal = 1'b0;
            end
            3'b101: begin
              // C.J becomes jal x0 with the scrambled offset rebuilt
              expanded    = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                             c[12], {8{c[12]}}, 5'b0, `OPC_JAL};
              rvc_illegal = 1'b0;
            end
            3'b110, 3'b111: begin
              // C.BEQZ / C.BNEZ compare rs1' against x0, funct3 bit 0 from c[13]
              expanded    = {c[12], c[12], c[12], c[12], c[6:5], c[2], 5'b0, rs1_p,
                             2'b00, c[13], c[11:10], c[4:3], c[12], `OPC_BRANCH};
              rvc_illegal = 1'b0;
            end
            default: begin
              expanded    = '0;
              rvc_illegal = 1'b1;
            end
          endcase
        end

        // ------------------------------------------------------------------------
        // Quadrant 2
        // ------------------------------------------------------------------------
        2'b10: begin
          if (c[15:13] == 3'b100) begin
            if (!c[12]) begin
              if (c[6:2] == 5'b0) begin
                // C.JR, rs1 of zero is reserved
                if (c[11:7] != 5'b0) begin
                  expanded    = {12'b0, c[11:7], 3'b000, 5'b0, `OPC_JALR};
                  rvc_illegal = 1'b0;
                end
              end else begin
                // C.MV as add rd, x0, rs2
                expanded    = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], `OPC_OP};
                rvc_illegal = 1'b0;
              end
            end else if (c[6:2] != 5'b0) begin
              // C.ADD as add rd, rd, rs2
              expanded    = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], `OPC_OP};
              rvc_illegal = 1'b0;
            end
          end
        end

        default: begin
          expanded    = '0;
          rvc_illegal = 1'b1;
        end
      endcase
    end
  end

  assign exp.instr         = expanded;
  assign exp.fetch_instr   = fetch_instr_i;
  assign exp.is_compressed = compressed;
  assign exp.illegal       = rvc_illegal;

endmodule

// File: logic/instr_decoder.sv
/*
  Turns one 32-bit RV32I instruction into a scoreboard entry.
  Unknown opcodes and funct combinations give an illegal entry.
*/
`timescale 1ns/10ps
`include "decode_settings.svh"

module instr_decoder (
  expand_if.decoder              exp,
  input  logic [31:0]            pc_i,
  output decode_pkg::sb_entry_t  entry_o
);

  import decode_pkg::*;

  logic [`ILEN-1:0]       instr;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [31:0]            imm_i;
  logic [31:0]            imm_s;
  logic [31:0]            imm_b;
  logic [31:0]            imm_u;
  logic [31:0]            imm_j;
  fu_e                    fu;
  op_e                    op;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [31:0]            imm;
  logic                   ctrl_flow;
  logic                   unsupported;
  logic                   illegal;

  assign instr  = exp.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    fu          = FU_NONE;
    op          = ADD;
    rd          = '0;
    rs1         = '0;
    rs2         = '0;
    imm         = '0;
    ctrl_flow   = 1'b0;
    unsupported = 1'b0;

    case (opcode)
      `OPC_LUI, `OPC_AUIPC: begin
        fu  = FU_ALU;
        op  = (opcode == `OPC_LUI) ? LUI : AUIPC;
        rd  = instr[11:7];
        imm = imm_u;
      end
      `OPC_JAL: begin
        fu        = FU_BRANCH;
        op        = JAL;
        rd        = instr[11:7];
        imm       = imm_j;
        ctrl_flow = 1'b1;
      end
      `OPC_JALR: begin
        fu          = FU_BRANCH;
        op          = JALR;
        rd          = instr[11:7];
        rs1         = instr[19:15];
        imm         = imm_i;
        ctrl_flow   = 1'b1;
        unsupported = funct3 != 3'b000;
      end
      `OPC_BRANCH: begin
        fu        = FU_BRANCH;
        rs1       = instr[19:15];
        rs2       = instr[24:20];
        imm       = imm_b;
        ctrl_flow = 1'b1;
        case (funct3)
          3'b000:  op = EQ;
          3'b001:  op = NE;
          3'b100:  op = LT;
          3'b101:  op = GE;
          3'b110:  op = LTU;
          3'b111:  op = GEU;
          default: unsupported = 1'b1;
        endcase
      end
      `OPC_LOAD: begin
        // Byte and half loads map onto LW
        fu          = FU_LOAD;
        op          = LW;
        rd          = instr[11:7];
        rs1         = instr[19:15];
        imm         = imm_i;
        unsupported = funct3 inside {3'b011, 3'b110, 3'b111};
      end
      `OPC_STORE: begin
        fu          = FU_STORE;
        op          = SW;
        rs1         = instr[19:15];
        rs2         = instr[24:20];
        imm         = imm_s;
        unsupported = funct3[2] || (funct3 == 3'b011);
      end
      `OPC_OP_IMM: begin
        fu  = FU_ALU;
        rd  = instr[11:7];
        rs1 = instr[19:15];
        imm = imm_i;
        case (funct3)
          3'b000: op = ADD;
          3'b010: op = SLT;
          3'b011: op = SLTU;
          3'b100: op = XOR;
          3'b110: op = OR;
          3'b111: op = AND;
          3'b001: begin
            op          = SLL;
            imm         = {27'b0, instr[24:20]};
            unsupported = funct7 != 7'b0000000;
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            op          = funct7[5] ? SRA : SRL;
            imm         = {27'b0, instr[24:20]};
            unsupported = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      `OPC_OP: begin
        fu  = FU_ALU;
        rd  = instr[11:7];
        rs1 = instr[19:15];
        rs2 = instr[24:20];
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = SRL;
            3'b110:  op = OR;
            default: op = AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          op = SRA;
        end else begin
          unsupported = 1'b1;
        end
      end
      default: unsupported = 1'b1;
    endcase
  end

  assign illegal = exp.illegal || unsupported;

  // An illegal entry only keeps its pc and where it came from
  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.orig_instr    = exp.fetch_instr;
    entry_o.is_compressed = exp.is_compressed;
    entry_o.illegal       = illegal;
    entry_o.fu            = FU_NONE;
    entry_o.op            = ADD;
    if (!illegal) begin
      entry_o.fu           = fu;
      entry_o.op           = op;
      entry_o.rd           = rd;
      entry_o.rs1          = rs1;
      entry_o.rs2          = rs2;
      entry_o.imm          = imm;
      entry_o.is_ctrl_flow = ctrl_flow;
    end
  end

endmodule

// File: logic/issue_register.sv
/*
  Single entry register between decode and issue. Fetch is ready when
  the slot is empty or being acknowledged; flush drops the held entry.
*/
`timescale 1ns/10ps

module issue_register (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,
  input  decode_pkg::sb_entry_t entry_i,
  input  logic                  issue_ack_i,
  output logic                  issue_valid_o,
  output decode_pkg::sb_entry_t entry_o
);

  import decode_pkg::*;

  issue_reg_t issue_d;
  issue_reg_t issue_q;
  logic       take;

  assign fetch_ready_o = fetch_valid_i && (!issue_q.valid || issue_ack_i);
  assign take          = fetch_valid_i && fetch_ready_o;

  // --------------------------------------------------------------------------
  // Next state, later steps win
  // --------------------------------------------------------------------------
  always_comb begin
    issue_d = issue_q;
    if (issue_ack_i) begin
      issue_d.valid = 1'b0;
    end
    if (take) begin
      issue_d.valid = 1'b1;
      issue_d.sbe   = entry_i;
    end
    if (flush_i) begin
      issue_d.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_q <= '0;
    end else begin
      issue_q <= issue_d;
    end
  end

  assign issue_valid_o = issue_q.valid;
  assign entry_o       = issue_q.sbe;

endmodule

// File: logic/id_stage.sv
/*
  Instruction decode stage top level. Fetch words are expanded, decoded
  and held for the issue side, which takes them with issue_ack_i.
*/
`timescale 1ns/10ps
`include "decode_settings.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  // Fetch side
  input  logic                   fetch_valid_i,
  input  logic [`ILEN-1:0]       fetch_instr_i,
  input  logic [31:0]            fetch_pc_i,
  output logic                   fetch_ready_o,
  // Issue side
  output logic                   issue_valid_o,
  input  logic                   issue_ack_i,
  output logic [31:0]            issue_pc_o,
  output decode_pkg::fu_e        issue_fu_o,
  output decode_pkg::op_e        issue_op_o,
  output logic [`REG_ADDR_W-1:0] issue_rd_o,
  output logic [`REG_ADDR_W-1:0] issue_rs1_o,
  output logic [`REG_ADDR_W-1:0] issue_rs2_o,
  output logic [31:0]            issue_imm_o,
  output logic                   issue_illegal_o,
  output logic                   issue_compressed_o,
  output logic                   is_ctrl_flow_o,
  output logic [`ILEN-1:0]       orig_instr_o
);

  import decode_pkg::*;

  sb_entry_t decoded_entry;
  sb_entry_t held_entry;

  expand_if exp_bus ();

  rvc_expander u_expander (
    .fetch_instr_i (fetch_instr_i),
    .exp           (exp_bus.expander)
  );

  instr_decoder u_decoder (
    .exp     (exp_bus.decoder),
    .pc_i    (fetch_pc_i),
    .entry_o (decoded_entry)
  );

  issue_register u_issue_reg (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .entry_i       (decoded_entry),
    .issue_ack_i   (issue_ack_i),
    .issue_valid_o (issue_valid_o),
    .entry_o       (held_entry)
  );

  // Held entry onto the plain issue ports
  assign issue_pc_o         = held_entry.pc;
  assign issue_fu_o         = held_entry.fu;
  assign issue_op_o         = held_entry.op;
  assign issue_rd_o         = held_entry.rd;
  assign issue_rs1_o        = held_entry.rs1;
  assign issue_rs2_o        = held_entry.rs2;
  assign issue_imm_o        = held_entry.imm;
  assign issue_illegal_o    = held_entry.illegal;
  assign issue_compressed_o = held_entry.is_compressed;
  assign is_ctrl_flow_o     = held_entry.is_ctrl_flow;
  assign orig_instr_o       = held_entry.orig_instr;

endmodule

// File: test/id_stage_asserts.sv
/*
  Handshake and flush assertions for the decode stage, bound to id_stage.
  The testbench watches the failure count.
*/
`timescale 1ns/10ps

module id_stage_asserts (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        flush_i,
  input logic        fetch_valid_i,
  input logic        fetch_ready_o,
  input logic        issue_valid_o,
  input logic        issue_ack_i,
  input logic [31:0] issue_pc_o,
  input logic [31:0] issue_imm_o,
  input logic [31:0] orig_instr_o,
  input logic [4:0]  issue_rd_o
);

  int failures = 0;

  // Held entry stays put until ack
  hold_outputs: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i && !flush_i |=> issue_valid_o && $stable(issue_pc_o)
      && $stable(issue_imm_o) && $stable(orig_instr_o) && $stable(issue_rd_o))
    else begin $error("issue outputs changed before ack"); failures++; end

  hold_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ack_i |-> !fetch_ready_o)
    else begin $error("fetch_ready_o high while entry is held"); failures++; end

  idle_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !fetch_valid_i |-> !fetch_ready_o)
    else begin $error("fetch_ready_o high without fetch_valid_i"); failures++; end

  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !issue_valid_o)
    else begin $error("issue_valid_o high after flush"); failures++; end

  reset_empty: assert property (@(posedge clk_i) !rst_ni |-> !issue_valid_o)
    else begin $error("issue_valid_o high during reset"); failures++; end

endmodule

bind id_stage id_stage_asserts u_asserts (.*);

// File: test/id_stage_tb.sv
/*
  Testbench for the decode stage. Drives fetch words with random gaps,
  acknowledges with random delays and checks every issued entry against
  values built from the instruction fields.
*/
`timescale 1ns/10ps
`include "decode_settings.svh"

module id_stage_tb;

  import decode_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        fetch_valid_i;
  logic [31:0] fetch_instr_i;
  logic [31:0] fetch_pc_i;
  logic        fetch_ready_o;
  logic        issue_valid_o;
  logic        issue_ack_i;
  logic [31:0] issue_pc_o;
  fu_e         issue_fu_o;
  op_e         issue_op_o;
  logic [4:0]  issue_rd_o;
  logic [4:0]  issue_rs1_o;
  logic [4:0]  issue_rs2_o;
  logic [31:0] issue_imm_o;
  logic        issue_illegal_o;
  logic        issue_compressed_o;
  logic        is_ctrl_flow_o;
  logic [31:0] orig_instr_o;

  integer      seed;
  int          taken_cnt;
  int          issued_cnt;
  int          flushed_cnt;
  logic [31:0] next_pc;
  logic [31:0] second_pc;

  id_stage uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Instruction encoders
  // --------------------------------------------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

  // --------------------------------------------------------------------------
  // Checks and handshakes
  // --------------------------------------------------------------------------
  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("** Error %s %s: expected %h, actual %h", name, field, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Present a word at the falling edge and hold it until it is taken
  task automatic take_word(input logic [31:0] word, input logic with_flush);
    int t;
    fetch_valid_i = 1'b1;
    fetch_instr_i = word;
    fetch_pc_i    = next_pc;
    flush_i       = with_flush;
    t = 0;
    #1;
    while (!fetch_ready_o) begin
      @(negedge clk_i);
      #1;
      t++;
      if (t > 50) stop_on_failure("Timeout: fetch word was never taken");
    end
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
    flush_i       = 1'b0;
    next_pc += 4;
  endtask

  task automatic wait_issue();
    int t;
    t = 0;
    while (!issue_valid_o) begin
      @(negedge clk_i);
      t++;
      if (t > 50) stop_on_failure("Timeout: no entry appeared on the issue side");
    end
  endtask

  task automatic ack_entry();
    repeat ($unsigned($random(seed)) % 4) @(negedge clk_i);
    issue_ack_i = 1'b1;
    @(negedge clk_i);
    issue_ack_i = 1'b0;
  endtask

  task automatic run_case(input string name, input logic [31:0] word, input fu_e fu,
                          input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2, input logic [31:0] imm, input logic ctrl,
                          input logic comp, input logic ill);
    logic [31:0] pc;
    repeat ($unsigned($random(seed)) % 3) @(negedge clk_i);
    pc = next_pc;
    take_word(word, 1'b0);
    wait_issue();
    check_field(name, "pc", pc, issue_pc_o);
    check_field(name, "fu", fu, issue_fu_o);
    check_field(name, "op", op, issue_op_o);
    check_field(name, "rd", rd, issue_rd_o);
    check_field(name, "rs1", rs1, issue_rs1_o);
    check_field(name, "rs2", rs2, issue_rs2_o);
    check_field(name, "imm", imm, issue_imm_o);
    check_field(name, "ctrl_flow", ctrl, is_ctrl_flow_o);
    check_field(name, "compressed", comp, issue_compressed_o);
    check_field(name, "illegal", ill, issue_illegal_o);
    check_field(name, "orig_instr", word, orig_instr_o);
    ack_entry();
  endtask

  task automatic run_illegal(input string name, input logic [31:0] word, input logic comp);
    run_case(name, word, FU_NONE, ADD, 5'd0, 5'd0, 5'd0, 32'd0, 1'b0, comp, 1'b1);
  endtask

  // Handshakes seen at the DUT ports
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (fetch_valid_i && fetch_ready_o) taken_cnt++;
      if (issue_valid_o && issue_ack_i) issued_cnt++;
    end
  end

  // Bound protocol assertions count their failures
  always @(negedge clk_i) begin
    if (uut.u_asserts.failures != 0) stop_on_failure("A protocol assertion failed");
  end

  initial begin
    seed          = 35522;
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_pc_i    = '0;
    issue_ack_i   = 1'b0;
    taken_cnt     = 0;
    issued_cnt    = 0;
    flushed_cnt   = 0;
    next_pc       = 32'h0000_1000;
    second_pc     = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_field("reset", "issue_valid", 1'b0, issue_valid_o);

    // One instance of each 32-bit opcode
    run_case("lui", {20'h12345, 5'd3, `OPC_LUI}, FU_ALU, LUI, 5'd3, 5'd0, 5'd0,
             32'h1234_5000, 1'b0, 1'b0, 1'b0);
    run_case("auipc", {20'hfffff, 5'd4, `OPC_AUIPC}, FU_ALU, AUIPC, 5'd4, 5'd0, 5'd0,
             32'hffff_f000, 1'b0, 1'b0, 1'b0);
    run_case("jal", enc_j(21'h1ffff0, 5'd1, `OPC_JAL), FU_BRANCH, JAL, 5'd1, 5'd0, 5'd0,
             32'hffff_fff0, 1'b1, 1'b0, 1'b0);
    run_case("jalr", enc_i(12'd12, 5'd2, 3'd0, 5'd1, `OPC_JALR), FU_BRANCH, JALR, 5'd1,
             5'd2, 5'd0, 32'd12, 1'b1, 1'b0, 1'b0);
    run_case("bne", enc_b(13'h1ff8, 5'd4, 5'd3, 3'd1, `OPC_BRANCH), FU_BRANCH, NE, 5'd0,
             5'd3, 5'd4, 32'hffff_fff8, 1'b1, 1'b0, 1'b0);
    run_case("lw", enc_i(12'hffc, 5'd6, 3'd2, 5'd5, `OPC_LOAD), FU_LOAD, LW, 5'd5, 5'd6,
             5'd0, 32'hffff_fffc, 1'b0, 1'b0, 1'b0);
    run_case("sw", enc_s(12'd20, 5'd7, 5'd8, 3'd2, `OPC_STORE), FU_STORE, SW, 5'd0, 5'd8,
             5'd7, 32'd20, 1'b0, 1'b0, 1'b0);
    run_case("xori", enc_i(12'h7ff, 5'd10, 3'd4, 5'd9, `OPC_OP_IMM), FU_ALU, XOR, 5'd9,
             5'd10, 5'd0, 32'h7ff, 1'b0, 1'b0, 1'b0);
    run_case("sub", enc_r(7'h20, 5'd13, 5'd12, 3'd0, 5'd11, `OPC_OP), FU_ALU, SUB, 5'd11,
             5'd12, 5'd13, 32'd0, 1'b0, 1'b0, 1'b0);

    // Compressed words next to their 32-bit equivalents
    run_case("c.addi", 32'h14f5, FU_ALU, ADD, 5'd9, 5'd9, 5'd0, 32'hffff_fffd, 1'b0, 1'b1, 1'b0);
    run_case("addi", enc_i(12'hffd, 5'd9, 3'd0, 5'd9, `OPC_OP_IMM), FU_ALU, ADD, 5'd9, 5'd9,
             5'd0, 32'hffff_fffd, 1'b0, 1'b0, 1'b0);
    run_case("c.li", 32'h4515, FU_ALU, ADD, 5'd10, 5'd0, 5'd0, 32'd5, 1'b0, 1'b1, 1'b0);
    run_case("li", enc_i(12'd5, 5'd0, 3'd0, 5'd10, `OPC_OP_IMM), FU_ALU, ADD, 5'd10, 5'd0,
             5'd0, 32'd5, 1'b0, 1'b0, 1'b0);
    run_case("c.mv", 32'h85b2, FU_ALU, ADD, 5'd11, 5'd0, 5'd12, 32'd0, 1'b0, 1'b1, 1'b0);
    run_case("mv", enc_r(7'h0, 5'd12, 5'd0, 3'd0, 5'd11, `OPC_OP), FU_ALU, ADD, 5'd11, 5'd0,
             5'd12, 32'd0, 1'b0, 1'b0, 1'b0);
    run_case("c.add", 32'h95b2, FU_ALU, ADD, 5'd11, 5'd11, 5'd12, 32'd0, 1'b0, 1'b1, 1'b0);
    run_case("add", enc_r(7'h0, 5'd12, 5'd11, 3'd0, 5'd11, `OPC_OP), FU_ALU, ADD, 5'd11,
             5'd11, 5'd12, 32'd0, 1'b0, 1'b0, 1'b0);
    run_case("c.jr", 32'h8282, FU_BRANCH, JALR, 5'd0, 5'd5, 5'd0, 32'd0, 1'b1, 1'b1, 1'b0);
    run_case("jr", enc_i(12'd0, 5'd5, 3'd0, 5'd0, `OPC_JALR), FU_BRANCH, JALR, 5'd0, 5'd5,
             5'd0, 32'd0, 1'b1, 1'b0, 1'b0);
    run_case("c.j", 32'ha021, FU_BRANCH, JAL, 5'd0, 5'd0, 5'd0, 32'd8, 1'b1, 1'b1, 1'b0);
    run_case("j", enc_j(21'd8, 5'd0, `OPC_JAL), FU_BRANCH, JAL, 5'd0, 5'd0, 5'd0, 32'd8,
             1'b1, 1'b0, 1'b0);
    run_case("c.lw", 32'h4144, FU_LOAD, LW, 5'd9, 5'd10, 5'd0, 32'd4, 1'b0, 1'b1, 1'b0);
    run_case("lw4", enc_i(12'd4, 5'd10, 3'd2, 5'd9, `OPC_LOAD), FU_LOAD, LW, 5'd9, 5'd10,
             5'd0, 32'd4, 1'b0, 1'b0, 1'b0);
    run_case("c.sw", 32'hc504, FU_STORE, SW, 5'd0, 5'd10, 5'd9, 32'd8, 1'b0, 1'b1, 1'b0);
    run_case("sw8", enc_s(12'd8, 5'd9, 5'd10, 3'd2, `OPC_STORE), FU_STORE, SW, 5'd0, 5'd10,
             5'd9, 32'd8, 1'b0, 1'b0, 1'b0);
    run_case("c.beqz", 32'hc011, FU_BRANCH, EQ, 5'd0, 5'd8, 5'd0, 32'd4, 1'b1, 1'b1, 1'b0);
    run_case("beqz", enc_b(13'd4, 5'd0, 5'd8, 3'd0, `OPC_BRANCH), FU_BRANCH, EQ, 5'd0, 5'd8,
             5'd0, 32'd4, 1'b1, 1'b0, 1'b0);
    run_case("c.bnez", 32'hfffd, FU_BRANCH, NE, 5'd0, 5'd15, 5'd0, 32'hffff_fffe, 1'b1, 1'b1,
             1'b0);
    run_case("bnez", enc_b(13'h1ffe, 5'd0, 5'd15, 3'd1, `OPC_BRANCH), FU_BRANCH, NE, 5'd0,
             5'd15, 5'd0, 32'hffff_fffe, 1'b1, 1'b0, 1'b0);

    // Illegal words
    run_illegal("zero", 32'h0000_0000, 1'b1);
    run_illegal("custom0", 32'h0000_000b, 1'b0);
    run_illegal("opcode7f", 32'h0000_007f, 1'b0);
    run_illegal("c.ld", 32'h0000_6000, 1'b1);

    // Next word waits at the input while the previous entry is held
    take_word(enc_i(12'd3, 5'd3, 3'd0, 5'd3, `OPC_OP_IMM), 1'b0);
    wait_issue();
    second_pc = next_pc;
    fork
      take_word(enc_i(12'd4, 5'd4, 3'd0, 5'd4, `OPC_OP_IMM), 1'b0);
      begin
        @(negedge clk_i);
        ack_entry();
      end
    join
    check_field("back_pressure", "issue_valid", 1'b1, issue_valid_o);
    check_field("back_pressure", "pc", second_pc, issue_pc_o);
    check_field("back_pressure", "orig_instr", enc_i(12'd4, 5'd4, 3'd0, 5'd4, `OPC_OP_IMM),
                orig_instr_o);
    ack_entry();

    // Flush on the same edge as a take
    take_word(enc_i(12'd1, 5'd1, 3'd0, 5'd1, `OPC_OP_IMM), 1'b1);
    check_field("flush_take", "issue_valid", 1'b0, issue_valid_o);
    flushed_cnt++;

    // Flush of a held entry
    take_word(enc_i(12'd2, 5'd2, 3'd0, 5'd2, `OPC_OP_IMM), 1'b0);
    wait_issue();
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_field("flush_held", "issue_valid", 1'b0, issue_valid_o);
    flushed_cnt++;

    check_field("count", "entries", taken_cnt, issued_cnt + flushed_cnt);
    repeat (2) @(negedge clk_i);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
logic/decode_pkg.sv
logic/expand_if.sv
logic/rvc_expander.sv
logic/instr_decoder.sv
logic/issue_register.sv
logic/id_stage.sv
test/id_stage_asserts.sv
test/id_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module id_stage_tb -Mdir obj_dir \
  && ./obj_dir/Vid_stage_tb | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
